//--- dv/uartRxGolden.txt
# Columns: command, test name, fields a b c in hex, repeat count n (a steps by one per repeat)
# wr a=addr b=data | rd a=addr b=expected | send a=byte b=divisor c=stop bit
# pop a=expected dataOut | stat a={empty,halfFull,full,overflow}
stat rst_status  8  0  0 1
rd   rst_div     0  08 0 1
wr   div_zero    0  00 0 1
rd   div_as_one  0  01 0 1
wr   div_4       0  04 0 1
rd   div_4_rd    0  04 0 1
send ord_a       a5 4  1 1
wr   div_2       0  02 0 1
send ord_b       3c 2  1 1
pop  ord_pop_a   a5 0  0 1
pop  ord_pop_b   3c 0  0 1
wr   div_1       0  01 0 1
send fill_lo     10 1  1 8
stat half_full   4  0  0 1
send fill_hi     18 1  1 8
stat full        6  0  0 1
send overflow    ee 1  1 1
stat ovf_set     7  0  0 1
rd   ovf_seen    2  1e 0 1
pop  pop_first   10 0  0 1
rd   seen_stays  2  12 0 1
wr   ovf_clr     2  10 0 1
pop  drain       11 0  0 f
send keep        81 1  1 2
send frame_bad   55 1  0 1
rd   ferr_seen   2  20 0 1
wr   ferr_clr    2  20 0 1
wr   bist_on     1  01 0 1
rd   bist_rd     1  01 0 1
send frozen      c3 1  1 2
pop  frozen_pop  1f 0  0 1
stat frozen_st   0  0  0 1
wr   bist_off    1  00 0 1
pop  thaw        81 0  0 2
stat thaw_empty  8  0  0 1
pop  empty_pop   82 0  0 1
rd   all_clear   2  01 0 1

//--- uartRxTop.f
verilog/uartRxPkg.sv
verilog/baudTicker.sv
verilog/uartRxCore.sv
verilog/rxFifo.sv
verilog/uartRxRegs.sv
verilog/uartRxTop.sv
dv/uartRxTb.sv

//--- run.sh
#!/bin/sh
# Build and run the UART receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f uartRxTop.f --top-module uartRxTb -o uartRxSim
if [ $? -ne 0 ]; then
        echo "Verilator build failed"
        exit 1
fi

./obj_dir/uartRxSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
        exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- dv/uartRxTb.sv
`timescale 1ns/100ps
`default_nettype none

module uartRxTb;
        import uartRxPkg::*;

        localparam int NAME_CHARS = 16;
        localparam int FRAME_BITS = 10;         // Start, eight data bits, stop
        localparam int MAX_IDLE   = 7;          // Largest idle gap the LFSR can pick
        localparam int MARGIN     = 500;

        typedef logic [8*NAME_CHARS-1:0] name_t;
        typedef logic [63:0]             token_t;

        logic                 clk = 1'b0;
        logic                 rst;
        logic                 rxd;
        logic                 popData;
        logic [DATA_BITS-1:0] dataOut;
        fifoStatus_t          fifoStat;
        logic                 cfgWrite;
        regAddr_t             cfgAddr;
        logic [7:0]           cfgWData;
        logic [7:0]           cfgRData;

        logic [7:0] lfsr        = 8'd25;
        int         strobeCount = 0;    // Frames ended by the receiver
        int         cycleCount  = 0;
        int         cycleLimit  = 0;

        uartRxTop i_dut (
                .clk      (clk),
                .rst      (rst),
                .rxd      (rxd),
                .popData  (popData),
                .dataOut  (dataOut),
                .fifoStat (fifoStat),
                .cfgWrite (cfgWrite),
                .cfgAddr  (cfgAddr),
                .cfgWData (cfgWData),
                .cfgRData (cfgRData)
        );

        always #2 clk = ~clk;

        always @(posedge clk)
        begin
                if (!rst && (i_dut.byteValid || i_dut.frameErr))
                        strobeCount <= strobeCount + 1;
        end

        always @(posedge clk)
        begin
                cycleCount <= cycleCount + 1;
                if (cycleCount >= cycleLimit)
                begin
                        $display("Run did not finish within %0d cycles", cycleLimit);
                        reportFail();
                end
        end

        ////////////////////////////////////////
        // Helpers
        ////////////////////////////////////////

        task automatic reportFail();
                $display("=== FAIL ===");
                $fatal(1);
        endtask

        // Taps for x^8 + x^6 + x^5 + x^4 + 1
        function automatic logic [7:0] lfsrNext(input logic [7:0] s);
                return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
        endfunction

        task automatic checkByte(input name_t name, input logic [DATA_BITS-1:0] expected,
                                 input logic [DATA_BITS-1:0] actual);
                if (actual !== expected)
                begin
                        $display("error %0s expected %h actual %h", name, expected, actual);
                        reportFail();
                end
        endtask

        task automatic checkStatus(input name_t name, input fifoStatus_t expected,
                                   input fifoStatus_t actual);
                if (actual !== expected)
                begin
                        $display("error %0s expected %b actual %b", name, expected, actual);
                        reportFail();
                end
        endtask

        task automatic checkReg(input name_t name, input logic [7:0] expected,
                                input logic [7:0] actual);
                if (actual !== expected)
                begin
                        $display("error %0s expected %h actual %h", name, expected, actual);
                        reportFail();
                end
        endtask

        ////////////////////////////////////////
        // Bus and line drivers
        ////////////////////////////////////////

        task automatic writeReg(input regAddr_t addr, input logic [7:0] value);
                cfgAddr  = addr;
                cfgWData = value;
                cfgWrite = 1'b1;
                @(negedge clk);
                cfgWrite = 1'b0;
        endtask

        task automatic readExpect(input name_t name, input regAddr_t addr,
                                  input logic [7:0] expected);
                cfgAddr = addr;
                @(negedge clk);
                checkReg(name, expected, cfgRData);
        endtask

        // dataOut is read in the cycle after the pop edge
        task automatic popExpect(input name_t name, input logic [DATA_BITS-1:0] expected);
                popData = 1'b1;
                @(negedge clk);
                popData = 1'b0;
                checkByte(name, expected, dataOut);
        endtask

        task automatic sendFrame(input logic [7:0] value, input int divisor, input logic stopBit);
                int         bitClocks;
                int         idleBits;
                int         startCount;
                logic [9:0] frame;
                bitClocks = OVERSAMPLE * divisor;
                frame     = {stopBit, value, 1'b0};
                idleBits  = 0;
                // A low stop bit can start a false frame, so let the receiver settle
                while (i_dut.core.state != IDLE || i_dut.byteValid || i_dut.frameErr)
                        @(negedge clk);
                startCount = strobeCount;
                for (int i = 0; i < 3; i++)
                begin
                        idleBits = idleBits * 2 + int'(lfsr[7]);
                        lfsr     = lfsrNext(lfsr);
                end
                repeat (idleBits * bitClocks) @(negedge clk);
                for (int i = 0; i < FRAME_BITS; i++)
                begin
                        rxd = frame[i];                 // LSB first after the start bit
                        repeat (bitClocks) @(negedge clk);
                end
                rxd = 1'b1;
                while (strobeCount == startCount)
                        @(negedge clk);
        endtask

        ////////////////////////////////////////
        // Golden file player
        ////////////////////////////////////////

        task automatic runCommand(input token_t cmd, input name_t name, input logic [31:0] a,
                                  input logic [31:0] b, input logic [31:0] c);
                if (cmd == token_t'("wr"))
                        writeReg(regAddr_t'(a[1:0]), b[7:0]);
                else if (cmd == token_t'("rd"))
                        readExpect(name, regAddr_t'(a[1:0]), b[7:0]);
                else if (cmd == token_t'("send"))
                        sendFrame(a[7:0], int'(b), c[0]);
                else if (cmd == token_t'("pop"))
                        popExpect(name, a[DATA_BITS-1:0]);
                else if (cmd == token_t'("stat"))
                        checkStatus(name, fifoStatus_t'(a[3:0]), fifoStat);
                else
                begin
                        $display("Unknown command %0s in the golden file", cmd);
                        reportFail();
                end
        endtask

        // First pass sizes the timeout, second pass plays the commands
        task automatic walkGolden(input bit execute);
                int              fd;
                int              fields;
                logic [8*96-1:0] line;
                token_t          cmd;
                name_t           name;
                logic [31:0]     a;
                logic [31:0]     b;
                logic [31:0]     c;
                logic [31:0]     n;
                fd = $fopen("dv/uartRxGolden.txt", "r");
                if (fd == 0)
                begin
                        $display("Cannot open the golden file dv/uartRxGolden.txt");
                        reportFail();
                end
                else
                begin
                        while ($fgets(line, fd) != 0)
                        begin
                                cmd    = '0;
                                fields = $sscanf(line, "%s %s %h %h %h %h", cmd, name, a, b, c, n);
                                if (fields == 6 && cmd != token_t'("#"))
                                begin
                                        for (int i = 0; i < int'(n); i++)
                                        begin
                                                if (!execute && cmd == token_t'("send"))
                                                        cycleLimit += (2 * FRAME_BITS + MAX_IDLE)
                                                                      * OVERSAMPLE * int'(b);
                                                else if (!execute)
                                                        cycleLimit += 4;
                                                else
                                                        runCommand(cmd, name, a + 32'(i), b, c);
                                        end
                                end
                        end
                        $fclose(fd);
                end
        endtask

        initial
        begin
                rst      = 1'b1;
                rxd      = 1'b1;                // Idle line
                popData  = 1'b0;
                cfgWrite = 1'b0;
                cfgAddr  = ADDR_DIVISOR;
                cfgWData = '0;
                walkGolden(1'b0);
                cycleLimit += MARGIN;
                repeat (5) @(negedge clk);
                rst = 1'b0;
                walkGolden(1'b1);
                $display("=== PASS ===");
                $finish;
        end

endmodule

`default_nettype wire

//--- verilog/uartRxTop.sv
`timescale 1ns/100ps
`default_nettype none

module uartRxTop (
        input  logic                           clk,
        input  logic                           rst,
        input  logic                           rxd,
        input  logic                           popData,
        output logic [uartRxPkg::DATA_BITS-1:0] dataOut,
        output uartRxPkg::fifoStatus_t          fifoStat,
        input  logic                           cfgWrite,
        input  uartRxPkg::regAddr_t            cfgAddr,
        input  logic [7:0]                     cfgWData,
        output logic [7:0]                     cfgRData
);
        import uartRxPkg::*;

        rxConfig_t            cfg;
        logic                 tick;
        logic [DATA_BITS-1:0] rxByte;
        logic                 byteValid;
        logic                 frameErr;

        uartRxRegs regs (
                .clk      (clk),
                .rst      (rst),
                .cfgWrite (cfgWrite),
                .frameErr (frameErr),
                .cfgAddr  (cfgAddr),
                .cfgWData (cfgWData),
                .fifoStat (fifoStat),
                .cfg      (cfg),
                .cfgRData (cfgRData)
        );

        baudTicker ticker (
                .clk     (clk),
                .rst     (rst),
                .divisor (cfg.divisor),
                .tick    (tick)
        );

        // Serial line in, bytes and framing errors out
        uartRxCore core (
                .clk       (clk),
                .rst       (rst),
                .rxd       (rxd),
                .tick      (tick),
                .rxByte    (rxByte),
                .byteValid (byteValid),
                .frameErr  (frameErr)
        );

        rxFifo fifo (
                .clk       (clk),
                .rst       (rst),
                .byteValid (byteValid),
                .popData   (popData),
                .bistMode  (cfg.bistMode),
                .rxByte    (rxByte),
                .dataOut   (dataOut),
                .fifoStat  (fifoStat)
        );

endmodule

`default_nettype wire

//--- verilog/uartRxRegs.sv
`timescale 1ns/100ps
`default_nettype none

module uartRxRegs (
        input  logic                   clk,
        input  logic                   rst,
        input  logic                   cfgWrite,
        input  logic                   frameErr,
        input  uartRxPkg::regAddr_t    cfgAddr,
        input  logic [7:0]             cfgWData,
        input  uartRxPkg::fifoStatus_t fifoStat,
        output uartRxPkg::rxConfig_t   cfg,
        output logic [7:0]             cfgRData
);
        import uartRxPkg::*;

        logic overflowSeen;
        logic frameErrSeen;
        logic prevOverflow;     // For the rising edge of overflow

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        cfg.divisor  <= DIVISOR_BITS'(DEFAULT_DIVISOR);
                        cfg.bistMode <= 1'b0;
                        overflowSeen <= 1'b0;
                        frameErrSeen <= 1'b0;
                        prevOverflow <= 1'b0;
                end
                else
                begin
                        prevOverflow <= fifoStat.overflow;
                        if (cfgWrite && cfgAddr == ADDR_DIVISOR)
                                cfg.divisor <= (cfgWData == '0) ? DIVISOR_BITS'(1)
                                                                : cfgWData[DIVISOR_BITS-1:0];
                        if (cfgWrite && cfgAddr == ADDR_CONTROL)
                                cfg.bistMode <= cfgWData[0];

                        // Write one to clear, a new event on the same edge wins
                        if (cfgWrite && cfgAddr == ADDR_STATUS && cfgWData[4])
                                overflowSeen <= 1'b0;
                        if (fifoStat.overflow && !prevOverflow)
                                overflowSeen <= 1'b1;
                        if (cfgWrite && cfgAddr == ADDR_STATUS && cfgWData[5])
                                frameErrSeen <= 1'b0;
                        if (frameErr)
                                frameErrSeen <= 1'b1;
                end
        end

        ////////////////////////////////////////
        // Read mux
        ////////////////////////////////////////

        always_comb
        begin
                case (cfgAddr)
                ADDR_DIVISOR: cfgRData = 8'(cfg.divisor);
                ADDR_CONTROL: cfgRData = {7'b0, cfg.bistMode};
                ADDR_STATUS:  cfgRData = {2'b0, frameErrSeen, overflowSeen,
                                          fifoStat.overflow, fifoStat.full,
                                          fifoStat.halfFull, fifoStat.empty};
                default:      cfgRData = '0;    // Unmapped address
                endcase
        end

        divisorNonZero: assert property (@(posedge clk) disable iff (rst)
                (cfgWrite && cfgAddr == ADDR_DIVISOR) |=> (cfg.divisor != '0))
                else $error("Divisor register loaded with zero");

endmodule

`default_nettype wire

//--- verilog/rxFifo.sv
`timescale 1ns/100ps
`default_nettype none

module rxFifo (
        input  logic                           clk,
        input  logic                           rst,
        input  logic                           byteValid,
        input  logic                           popData,
        input  logic                           bistMode,
        input  logic [uartRxPkg::DATA_BITS-1:0] rxByte,
        output logic [uartRxPkg::DATA_BITS-1:0] dataOut,
        output uartRxPkg::fifoStatus_t          fifoStat
);
        import uartRxPkg::*;

        logic [DATA_BITS-1:0]      fifoMem [FIFO_DEPTH];
        logic [FIFO_ADDR_BITS-1:0] rdPtr;
        logic [FIFO_ADDR_BITS-1:0] wrPtr;
        logic [FIFO_ADDR_BITS:0]   count;       // One extra bit to hold FIFO_DEPTH
        logic                      overflowReg;
        logic                      isEmpty;
        logic                      isFull;
        logic                      pushOk;
        logic                      popOk;
        logic                      dropped;

        assign isEmpty = (count == '0);
        assign isFull  = (count == (FIFO_ADDR_BITS+1)'(FIFO_DEPTH));

        // Nothing moves while frozen for BIST
        assign pushOk  = byteValid && !bistMode && !isFull;
        assign popOk   = popData && !bistMode && !isEmpty;
        assign dropped = byteValid && !bistMode && isFull;

        ////////////////////////////////////////
        // Storage
        ////////////////////////////////////////

        always_ff @(posedge clk)
        begin
                if (pushOk)
                        fifoMem[wrPtr] <= rxByte;
        end

        ////////////////////////////////////////
        // Pointers, count and output byte
        ////////////////////////////////////////

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        rdPtr       <= '0;
                        wrPtr       <= '0;
                        count       <= '0;
                        overflowReg <= 1'b0;
                        dataOut     <= '0;
                end
                else
                begin
                        if (pushOk)
                                wrPtr <= wrPtr + 1'b1;
                        if (popOk)
                        begin
                                dataOut <= fifoMem[rdPtr];      // Head entry to output
                                rdPtr   <= rdPtr + 1'b1;
                        end
                        case ({pushOk, popOk})
                        2'b10:   count <= count + 1'b1;
                        2'b01:   count <= count - 1'b1;
                        default: count <= count;       // Both or neither
                        endcase

                        // A drop on the same edge as a pop still flags
                        if (popOk)
                                overflowReg <= 1'b0;
                        if (dropped)
                                overflowReg <= 1'b1;
                end
        end

        always_comb
        begin
                fifoStat.empty    = isEmpty;
                fifoStat.halfFull = (count >= (FIFO_ADDR_BITS+1)'(FIFO_DEPTH/2));
                fifoStat.full     = isFull;
                fifoStat.overflow = overflowReg;
        end

        countInRange: assert property (@(posedge clk) disable iff (rst)
                count <= (FIFO_ADDR_BITS+1)'(FIFO_DEPTH))
                else $error("FIFO count above depth");

endmodule

`default_nettype wire

//--- verilog/uartRxCore.sv
`timescale 1ns/100ps
`default_nettype none

module uartRxCore (
        input  logic                           clk,
        input  logic                           rst,
        input  logic                           rxd,
        input  logic                           tick,
        output logic [uartRxPkg::DATA_BITS-1:0] rxByte,
        output logic                           byteValid,
        output logic                           frameErr
);
        import uartRxPkg::*;

        rxState_t                         state;
        logic                             rxdMeta;
        logic                             rxdSync;
        logic [$clog2(OVERSAMPLE)-1:0]    tickCnt;    // Ticks since last sample point
        logic [$clog2(DATA_BITS)-1:0]     bitIdx;
        logic [DATA_BITS-1:0]             shiftReg;

        ////////////////////////////////////////
        // Line synchronizer
        ////////////////////////////////////////

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        rxdMeta <= 1'b1;        // Line idles high
                        rxdSync <= 1'b1;
                end
                else
                begin
                        rxdMeta <= rxd;
                        rxdSync <= rxdMeta;
                end
        end

        ////////////////////////////////////////
        // Frame FSM
        ////////////////////////////////////////

        always_ff @(posedge clk)
        begin
                if (rst)
                begin
                        state     <= IDLE;
                        tickCnt   <= '0;
                        bitIdx    <= '0;
                        byteValid <= 1'b0;
                        frameErr  <= 1'b0;
                end
                else
                begin
                        byteValid <= 1'b0;
                        frameErr  <= 1'b0;
                        if (tick)
                        begin
                                case (state)
                                IDLE:
                                begin
                                        if (!rxdSync)
                                        begin
                                                tickCnt <= ($clog2(OVERSAMPLE))'(1);  // First low tick
                                                state   <= START;
                                        end
                                end
                                START:
                                begin
                                        if (rxdSync)
                                                state <= IDLE;          // Glitch, not a start bit
                                        else if (tickCnt == ($clog2(OVERSAMPLE))'(OVERSAMPLE/2 - 1))
                                        begin
                                                // Eighth low tick, now at mid start bit
                                                tickCnt <= '0;
                                                bitIdx  <= '0;
                                                state   <= DATA;
                                        end
                                        else
                                                tickCnt <= tickCnt + 1'b1;
                                end
                                DATA:
                                begin
                                        if (tickCnt == ($clog2(OVERSAMPLE))'(OVERSAMPLE - 1))
                                        begin
                                                tickCnt <= '0;
                                                if (bitIdx == ($clog2(DATA_BITS))'(DATA_BITS - 1))
                                                        state <= STOP;
                                                else
                                                        bitIdx <= bitIdx + 1'b1;
                                        end
                                        else
                                                tickCnt <= tickCnt + 1'b1;
                                end
                                STOP:
                                begin
                                        if (tickCnt == ($clog2(OVERSAMPLE))'(OVERSAMPLE - 1))
                                        begin
                                                tickCnt   <= '0;
                                                byteValid <= rxdSync;   // Good stop bit
                                                frameErr  <= !rxdSync;
                                                state     <= IDLE;
                                        end
                                        else
                                                tickCnt <= tickCnt + 1'b1;
                                end
                                default:
                                        state <= IDLE;
                                endcase
                        end
                end
        end

        // LSB arrives first, so shift in from the top
        always_ff @(posedge clk)
        begin
                if (tick && state == DATA && tickCnt == ($clog2(OVERSAMPLE))'(OVERSAMPLE - 1))
                        shiftReg <= {rxdSync, shiftReg[DATA_BITS-1:1]};
        end

        assign rxByte = shiftReg;

        noDoubleStrobe: assert property (@(posedge clk) disable iff (rst)
                !(byteValid && frameErr))
                else $error("byteValid and frameErr asserted together");

endmodule

`default_nettype wire

//--- verilog/baudTicker.sv
`timescale 1ns/100ps
`default_nettype none

module baudTicker (
        input  logic                              clk,
        input  logic                              rst,
        input  logic [uartRxPkg::DIVISOR_BITS-1:0] divisor,
        output logic                              tick
);
        import uartRxPkg::*;

        logic [DIVISOR_BITS-1:0] count;
        logic [DIVISOR_BITS-1:0] prevDivisor;   // Detects a rate change

        always_ff @(posedge clk)
        begin
                prevDivisor <= divisor;
                if (rst)
                begin
                        count <= divisor - 1'b1;
                        tick  <= 1'b0;
                end
                else if (divisor != prevDivisor)
                begin
                        // New rate, start a fresh full period
                        count <= divisor - 1'b1;
                        tick  <= 1'b0;
                end
                else if (count == '0)
                begin
                        count <= divisor - 1'b1;
                        tick  <= 1'b1;          // One pulse per divisor clocks
                end
                else
                begin
                        count <= count - 1'b1;
                        tick  <= 1'b0;
                end
        end

endmodule

`default_nettype wire

//--- verilog/uartRxPkg.sv
`default_nettype none

package uartRxPkg;

        ////////////////////////////////////////
        // Sizes
        ////////////////////////////////////////

        localparam int DATA_BITS       = 8;
        localparam int FIFO_ADDR_BITS  = 4;
        localparam int FIFO_DEPTH      = 16;    // 2**FIFO_ADDR_BITS entries
        localparam int OVERSAMPLE      = 16;    // Ticks per bit time
        localparam int DIVISOR_BITS    = 8;
        localparam int DEFAULT_DIVISOR = 8;
        localparam int REG_ADDR_BITS   = 2;

        ////////////////////////////////////////
        // Encodings
        ////////////////////////////////////////

        typedef enum logic [1:0] {
                IDLE,
                START,
                DATA,
                STOP
        } rxState_t;

        typedef enum logic [REG_ADDR_BITS-1:0] {
                ADDR_DIVISOR = 2'd0,
                ADDR_CONTROL = 2'd1,
                ADDR_STATUS  = 2'd2
        } regAddr_t;

        ////////////////////////////////////////
        // Bundles
        ////////////////////////////////////////

        typedef struct packed {
                logic [DIVISOR_BITS-1:0] divisor;     // clk cycles per oversample tick
                logic                    bistMode;    // Freezes the FIFO
        } rxConfig_t;

        typedef struct packed {
                logic empty;
                logic halfFull;
                logic full;
                logic overflow;
        } fifoStatus_t;

endpackage

`default_nettype wire
